//--- testbench/cl_patterns.txt
# name op addr data dip led, all numbers in hex
# W writes data, R expects data, L sets dip and expects led
reset_hello_read R 500 00000000 0000 0000
reset_vled_read R 504 00000000 0000 0000
reset_led L 0 00000000 ffff 0000
write_hello_1 W 500 12345678 0000 0000
read_swap_1 R 500 78563412 0000 0000
read_vled_1 R 504 00005678 0000 0000
led_all_on L 0 00000000 ffff 5678
led_low_byte L 0 00000000 00ff 0078
led_all_off L 0 00000000 0000 0000
write_hello_2 W 500 deadbeef 0000 0000
read_swap_2 R 500 efbeadde 0000 0000
read_vled_2 R 504 0000beef 0000 0000
led_mask_f0f0 L 0 00000000 f0f0 b0e0
led_mask_0f0f L 0 00000000 0f0f 0e0f
read_unmapped_508 R 508 00000000 0000 0000
read_unmapped_0 R 0 00000000 0000 0000
write_unmapped W 600 cafef00d 0000 0000
read_after_unmapped R 500 efbeadde 0000 0000
write_hello_3 W 500 a5c30ff0 0000 0000
read_swap_3 R 500 f00fc3a5 0000 0000
read_vled_3 R 504 00000ff0 0000 0000
led_mask_3 L 0 00000000 ffff 0ff0

//--- files.f
hdl/cl_pkg.sv
hdl/reg_bus_if.sv
hdl/ocl_axil_slave.sv
hdl/cl_regs.sv
hdl/vled_status.sv
hdl/cl_hello_world.sv
testbench/cl_hello_world_sva.sv
testbench/tb_cl_hello_world.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hello-world testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_cl_hello_world \
  --Mdir obj_dir -o sim_cl_hello_world \
  -f files.f

# The log is searched below, so a nonzero simulator exit must not stop here
./obj_dir/sim_cl_hello_world > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
  exit 0
fi
exit 1

//--- testbench/tb_cl_hello_world.sv
/*
  Pattern-driven testbench for the OCL hello-world top.
  Runs from the project root and reads testbench/cl_patterns.txt.
  Inputs change on falling edges, responses are sampled 1 ns after them.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_cl_hello_world;

  logic          clk_main_a0;
  logic          rst_main_n_sync;
  logic          sh_ocl_awvalid;
  cl_pkg::addr_t sh_ocl_awaddr;
  logic          ocl_sh_awready;
  logic          sh_ocl_wvalid;
  cl_pkg::data_t sh_ocl_wdata;
  logic          ocl_sh_wready;
  logic          ocl_sh_bvalid;
  logic          sh_ocl_bready;
  logic          sh_ocl_arvalid;
  cl_pkg::addr_t sh_ocl_araddr;
  logic          ocl_sh_arready;
  logic          ocl_sh_rvalid;
  cl_pkg::data_t ocl_sh_rdata;
  logic          sh_ocl_rready;
  cl_pkg::vled_t sh_cl_status_vdip;
  cl_pkg::vled_t cl_sh_status_vled;

  // Pattern table with one entry per test line
  string         pat_name [$];
  string         pat_op [$];
  cl_pkg::addr_t pat_addr [$];
  cl_pkg::data_t pat_data [$];
  cl_pkg::vled_t pat_dip [$];
  cl_pkg::vled_t pat_led [$];
  bit            loaded = 1'b0;
  int            error_count = 0;
  int unsigned   lcg_state = 45;

  cl_hello_world #(
    .SYNC_STAGES (2)
  ) DUT (.*);

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #10 clk_main_a0 = ~clk_main_a0;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Back-pressure delay of 0 to 3 cycles
  function automatic int unsigned next_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % 4;
  endfunction

  task automatic check_value(input string name, input cl_pkg::data_t got,
                             input cl_pkg::data_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic load_patterns();
    int            fd;
    int            n;
    string         line;
    string         name;
    string         op;
    cl_pkg::addr_t a;
    cl_pkg::data_t d;
    cl_pkg::vled_t dip;
    cl_pkg::vled_t led;
    fd = $fopen("testbench/cl_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("The pattern file testbench/cl_patterns.txt could not be opened");
      error_count++;
      return;
    end
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      // Comment and blank lines carry no test
      if (line.len() == 0 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, dip, led);
      if (n == 6)
      begin
        pat_name.push_back(name);
        pat_op.push_back(op);
        pat_addr.push_back(a);
        pat_data.push_back(d);
        pat_dip.push_back(dip);
        pat_led.push_back(led);
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------
  // AXI-lite master tasks
  // --------------------------------------------------
  task automatic axil_write(input cl_pkg::addr_t addr, input cl_pkg::data_t data);
    int unsigned d;
    @(negedge clk_main_a0);
    sh_ocl_awvalid = 1'b1;
    sh_ocl_awaddr  = addr;
    #1;
    while (!ocl_sh_awready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    // AW beat on this edge
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_awvalid = 1'b0;
    sh_ocl_wvalid  = 1'b1;
    sh_ocl_wdata   = data;
    #1;
    while (!ocl_sh_wready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_wvalid = 1'b0;
    d = next_delay();
    repeat (d) @(negedge clk_main_a0);
    sh_ocl_bready = 1'b1;
    #1;
    while (!ocl_sh_bvalid)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_bready = 1'b0;
  endtask

  task automatic axil_read(input cl_pkg::addr_t addr, output cl_pkg::data_t data);
    int unsigned d;
    @(negedge clk_main_a0);
    sh_ocl_arvalid = 1'b1;
    sh_ocl_araddr  = addr;
    #1;
    while (!ocl_sh_arready)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_arvalid = 1'b0;
    #1;
    while (!ocl_sh_rvalid)
    begin
      @(negedge clk_main_a0);
      #1;
    end
    d = next_delay();
    repeat (d) @(negedge clk_main_a0);
    // rdata is held while rready stays low
    data          = ocl_sh_rdata;
    sh_ocl_rready = 1'b1;
    @(posedge clk_main_a0);
    @(negedge clk_main_a0);
    sh_ocl_rready = 1'b0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    int            i;
    int            errs_before;
    int            fail_count;
    cl_pkg::data_t rd;
    fail_count        = 0;
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_bready     = 1'b0;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b0;
    sh_cl_status_vdip = '0;
    load_patterns();
    loaded = 1'b1;
    repeat (2) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    for (i = 0; i < pat_name.size(); i++)
    begin
      errs_before = error_count;
      if (pat_op[i] == "W")
        axil_write(pat_addr[i], pat_data[i]);
      else if (pat_op[i] == "R")
      begin
        axil_read(pat_addr[i], rd);
        check_value("ocl_sh_rdata", rd, pat_data[i]);
      end
      else if (pat_op[i] == "L")
      begin
        @(negedge clk_main_a0);
        sh_cl_status_vdip = pat_dip[i];
        // Well past the SYNC_STAGES+1 latency
        repeat (8) @(negedge clk_main_a0);
        check_value("cl_sh_status_vled", cl_pkg::data_t'(cl_sh_status_vled),
                    cl_pkg::data_t'(pat_led[i]));
      end
      else
      begin
        $display("Test %s has an unknown op %s", pat_name[i], pat_op[i]);
        error_count++;
      end
      if (error_count == errs_before)
        $display("[TEST] %-20s ok", pat_name[i]);
      else
      begin
        fail_count++;
        $display("[TEST] %-20s mismatch", pat_name[i]);
      end
    end
    $display("Tests run %0d, tests failed %0d, errors %0d",
             pat_name.size(), fail_count, error_count);
    if (error_count == 0 && pat_name.size() > 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog allows 40 cycles per test plus slack for reset
  initial
  begin
    wait (loaded);
    repeat ((pat_name.size() + 4) * 40) @(posedge clk_main_a0);
    $display("The run timed out before all tests finished");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/cl_hello_world_sva.sv
/*
  Handshake assertions for the OCL AXI-lite slave, attached by bind.
  Needs a simulator run with assertions enabled.
*/
`timescale 1ns/100ps
`default_nettype none

module axil_slave_sva (
  input logic          clk_main_a0,
  input logic          rst_main_n_sync,
  input logic          awvalid,
  input logic          awready,
  input logic          bvalid,
  input logic          bready,
  input logic          rvalid,
  input logic          rready,
  input cl_pkg::data_t rdata
);

  // --------------------------------------------------
  // Response hold rules
  // --------------------------------------------------
  bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid fell before bready");

  // Payload frozen while the master stalls
  rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // No second address from the AW beat until the B beat
  aw_blocked: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    awvalid && awready |=> !awready)
    else $error("awready high right after an AW beat");

  aw_held: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    !awready && !(bvalid && bready) |=> !awready)
    else $error("awready rose before the B beat");

  // Both responses idle right after reset
  reset_idle: assert property (@(posedge clk_main_a0)
    !rst_main_n_sync |=> !bvalid && !rvalid)
    else $error("response valid high in the cycle after reset");

endmodule

bind ocl_axil_slave axil_slave_sva u_axil_slave_sva (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .awvalid         (awvalid),
  .awready         (awready),
  .bvalid          (bvalid),
  .bready          (bready),
  .rvalid          (rvalid),
  .rready          (rready),
  .rdata           (rdata)
);

`default_nettype wire

//--- hdl/cl_hello_world.sv
/*
  Control-logic top. OCL AXI-lite slave, hello-world register and virtual LEDs.
  Single clock, reset already synchronous to clk_main_a0.
*/
`timescale 1ns/100ps
`default_nettype none

module cl_hello_world #(
  parameter int SYNC_STAGES = 2
) (
  input  logic          clk_main_a0,
  input  logic          rst_main_n_sync,
  // OCL write address
  input  logic          sh_ocl_awvalid,
  input  cl_pkg::addr_t sh_ocl_awaddr,
  output logic          ocl_sh_awready,
  // OCL write data
  input  logic          sh_ocl_wvalid,
  input  cl_pkg::data_t sh_ocl_wdata,
  output logic          ocl_sh_wready,
  // OCL write response
  output logic          ocl_sh_bvalid,
  input  logic          sh_ocl_bready,
  // OCL read address
  input  logic          sh_ocl_arvalid,
  input  cl_pkg::addr_t sh_ocl_araddr,
  output logic          ocl_sh_arready,
  // OCL read data
  output logic          ocl_sh_rvalid,
  output cl_pkg::data_t ocl_sh_rdata,
  input  logic          sh_ocl_rready,
  // Virtual switches and LEDs
  input  cl_pkg::vled_t sh_cl_status_vdip,
  output cl_pkg::vled_t cl_sh_status_vled
);

  reg_bus_if     reg_bus ();
  cl_pkg::vled_t hello_low;
  cl_pkg::vled_t vled_shadow;

  // --------------------------------------------------
  // OCL bus slave
  // --------------------------------------------------
  ocl_axil_slave u_ocl_axil_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (sh_ocl_awvalid),
    .awaddr          (sh_ocl_awaddr),
    .awready         (ocl_sh_awready),
    .wvalid          (sh_ocl_wvalid),
    .wdata           (sh_ocl_wdata),
    .wready          (ocl_sh_wready),
    .bvalid          (ocl_sh_bvalid),
    .bready          (sh_ocl_bready),
    .arvalid         (sh_ocl_arvalid),
    .araddr          (sh_ocl_araddr),
    .arready         (ocl_sh_arready),
    .rvalid          (ocl_sh_rvalid),
    .rdata           (ocl_sh_rdata),
    .rready          (sh_ocl_rready),
    .bus             (reg_bus.slave_mp)
  );

  // --------------------------------------------------
  // Registers and LED path
  // --------------------------------------------------
  cl_regs u_cl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus             (reg_bus.regs_mp),
    .vled_shadow     (vled_shadow),
    .hello_low       (hello_low)
  );

  vled_status #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (sh_cl_status_vdip),
    .vled_shadow     (vled_shadow),
    .status_vled     (cl_sh_status_vled)
  );

endmodule

`default_nettype wire

//--- hdl/vled_status.sv
/*
  Virtual LED shadow and the DIP-masked LED status output.
  SYNC_STAGES must be 2 or more. DIP to LED latency is SYNC_STAGES+1 cycles.
*/
`timescale 1ns/100ps
`default_nettype none

module vled_status #(
  parameter int SYNC_STAGES = 2
) (
  input  logic          clk_main_a0,
  input  logic          rst_main_n_sync,
  input  cl_pkg::vled_t hello_low,
  input  cl_pkg::vled_t vdip,
  output cl_pkg::vled_t vled_shadow,
  output cl_pkg::vled_t status_vled
);

  // --------------------------------------------------
  // DIP synchronizer chain
  // --------------------------------------------------
  // Entry 0 samples the async switches, last entry is safe to use
  cl_pkg::vled_t dip_sync [SYNC_STAGES];

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
        dip_sync[i] <= '0;
    end
    else
    begin
      dip_sync[0] <= vdip;
      for (int i = 1; i < SYNC_STAGES; i++)
        dip_sync[i] <= dip_sync[i-1];
    end
  end

  // --------------------------------------------------
  // LED shadow and masked output
  // --------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vled_shadow <= '0;
      status_vled <= '0;
    end
    else
    begin
      // Shadow trails the hello-world register by one cycle
      vled_shadow <= hello_low;
      // A switch in the off position blanks its LED
      status_vled <= vled_shadow & dip_sync[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

//--- hdl/cl_regs.sv
/*
  Hello-world register and the OCL read decode.
  Unmapped reads return zero. Unmapped writes are dropped.
*/
`timescale 1ns/100ps
`default_nettype none

module cl_regs (
  input  logic          clk_main_a0,
  input  logic          rst_main_n_sync,
  reg_bus_if.regs_mp    bus,
  input  cl_pkg::vled_t vled_shadow,
  output cl_pkg::vled_t hello_low
);

  // --------------------------------------------------
  // Hello-world register
  // --------------------------------------------------
  cl_pkg::data_t hello_q;
  cl_pkg::data_t hello_swapped;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q <= '0;
    else if (bus.wr_en && (bus.wr_addr == cl_pkg::HELLO_WORLD_ADDR))
      hello_q <= bus.wr_data;
  end

  // Byte order reversed on readback
  assign hello_swapped = {<<8{hello_q}};

  // Low half feeds the LED shadow
  assign hello_low = hello_q[cl_pkg::VLED_W-1:0];

  // --------------------------------------------------
  // Read decode
  // --------------------------------------------------
  always_comb
  begin
    case (bus.rd_addr)
      cl_pkg::HELLO_WORLD_ADDR:
        bus.rd_data = hello_swapped;
      cl_pkg::VLED_ADDR:
        bus.rd_data = cl_pkg::data_t'(vled_shadow);
      // Anything else reads as zero
      default:
        bus.rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/ocl_axil_slave.sv
/*
  Single-beat AXI-lite slave for the OCL path. No WSTRB and no PROT.
  Responses are always OKAY, so BRESP and RRESP are not carried.
  Only one write and one read are in flight at a time.
*/
`timescale 1ns/100ps
`default_nettype none

module ocl_axil_slave (
  input  logic          clk_main_a0,
  input  logic          rst_main_n_sync,
  // Write address and data
  input  logic          awvalid,
  input  cl_pkg::addr_t awaddr,
  output logic          awready,
  input  logic          wvalid,
  input  cl_pkg::data_t wdata,
  output logic          wready,
  // Write response
  output logic          bvalid,
  input  logic          bready,
  // Read address and data
  input  logic          arvalid,
  input  cl_pkg::addr_t araddr,
  output logic          arready,
  output logic          rvalid,
  output cl_pkg::data_t rdata,
  input  logic          rready,
  // Register file side
  reg_bus_if.slave_mp   bus
);

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  logic          wr_active;
  cl_pkg::addr_t wr_addr_q;
  logic          aw_hs;
  logic          w_hs;
  logic          b_hs;

  // New address only while no write is open
  assign awready = ~wr_active;
  // Data accepted once per write and never again while B is pending
  assign wready  = wr_active & ~bvalid & wvalid;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end
    else
    begin
      // Open on AW, close on B
      if (aw_hs)
        wr_active <= 1'b1;
      else if (b_hs)
        wr_active <= 1'b0;
      // Response goes out on the same edge the register commits
      if (w_hs)
        bvalid <= 1'b1;
      else if (b_hs)
        bvalid <= 1'b0;
    end
  end

  // Address held for the W beat
  always_ff @(posedge clk_main_a0)
  begin
    if (aw_hs)
      wr_addr_q <= awaddr;
  end

  assign bus.wr_en   = w_hs;
  assign bus.wr_addr = wr_addr_q;
  assign bus.wr_data = wdata;

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  logic          rd_pend;
  logic          rd_wait;
  logic          rd_fire;
  cl_pkg::addr_t rd_addr_q;
  logic          ar_hs;
  logic          r_hs;

  assign arready = ~rd_pend & ~rvalid;
  assign ar_hs   = arvalid & arready;
  assign r_hs    = rvalid & rready;
  // Second edge after the AR beat
  assign rd_fire = rd_pend & rd_wait;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rd_pend <= 1'b0;
      rd_wait <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      if (ar_hs)
        rd_pend <= 1'b1;
      else if (rd_fire)
        rd_pend <= 1'b0;
      // One idle cycle for the decode to settle
      rd_wait <= rd_pend & ~rd_wait;
      if (rd_fire)
        rvalid <= 1'b1;
      else if (r_hs)
        rvalid <= 1'b0;
    end
  end

  // Read address and captured read data
  always_ff @(posedge clk_main_a0)
  begin
    if (ar_hs)
      rd_addr_q <= araddr;
    // Held until R handshake since rd_fire cannot recur before it
    if (rd_fire)
      rdata <= bus.rd_data;
  end

  assign bus.rd_addr = rd_addr_q;

endmodule

`default_nettype wire

//--- hdl/reg_bus_if.sv
/*
  Register access bus between the AXI-lite slave and the register file.
  wr_en is a single-cycle commit strobe. rd_data must be combinational from rd_addr.
*/
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

  // Write side commits on the edge where wr_en is high
  logic          wr_en;
  cl_pkg::addr_t wr_addr;
  cl_pkg::data_t wr_data;

  // Read side is a pure decode with no latency
  cl_pkg::addr_t rd_addr;
  cl_pkg::data_t rd_data;

  modport slave_mp (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_addr,
    input  rd_data
  );

  modport regs_mp (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

//--- hdl/cl_pkg.sv
/*
  Shared widths, word types and the OCL register map.
  The address map is fixed. Both registers are 32-bit, full-word access only.
*/
`default_nettype none

package cl_pkg;

  // --------------------------------------------------
  // Bus and LED widths
  // --------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One bit per virtual LED and per virtual DIP switch
  localparam int VLED_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [VLED_W-1:0] vled_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  // Written as a word, read back byte-reversed
  localparam addr_t HELLO_WORLD_ADDR = 32'h0000_0500;
  // Read-only LED shadow with the upper half reading as zero
  localparam addr_t VLED_ADDR        = 32'h0000_0504;

endpackage

`default_nettype wire
